// File: run_sim.sh
#!/bin/sh
# Build and run the AXI-lite SRAM testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --timing -Wno-fatal \
  --top-module tb_axi_sram -Mdir obj_dir -f tb.f > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_axi_sram > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^all tests passed$" "$SIM_LOG"; then
  exit 0
fi
exit 1

// File: src/axi_sram_pkg.sv
`default_nettype none

package axi_sram_pkg;

  // Bus widths
  localparam int data_w = 32;
  localparam int addr_w = 32;
  localparam int strb_w = data_w / 8;

  // Array geometry of 4 KiB in words
  localparam int mem_words  = 1024;
  localparam int word_idx_w = 10;

  // AXI response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // Latency source
  localparam logic [7:0] lfsr_seed = 8'haa;

  // Low LFSR bits kept as a wait count of 0 to 15 extra cycles
  localparam logic [3:0] lat_mask = 4'hf;

endpackage

`default_nettype wire

// File: src/axi_sram_slave.sv
`timescale 1ns/10ps
`default_nettype none

module axi_sram_slave (
  input  logic                                  clk,
  input  logic                                  rstn,
  // Read address
  input  logic [axi_sram_pkg::addr_w-1:0]      araddr,
  input  logic                                  arvalid,
  output logic                                  arready,
  // Read data
  output logic [axi_sram_pkg::data_w-1:0]      rdata,
  output logic [1:0]                            rresp,
  output logic                                  rvalid,
  input  logic                                  rready,
  // Write address
  input  logic [axi_sram_pkg::addr_w-1:0]      awaddr,
  input  logic                                  awvalid,
  output logic                                  awready,
  // Write data
  input  logic [axi_sram_pkg::data_w-1:0]      wdata,
  input  logic [axi_sram_pkg::strb_w-1:0]      wstrb,
  input  logic                                  wvalid,
  output logic                                  wready,
  // Write response
  output logic [1:0]                            bresp,
  output logic                                  bvalid,
  input  logic                                  bready,
  // Latency source
  input  logic [7:0]                            lfsr_value,
  // Array ports
  output logic [axi_sram_pkg::word_idx_w-1:0]  rd_idx,
  input  logic [axi_sram_pkg::data_w-1:0]      rd_data,
  output logic                                  wr_en,
  output logic [axi_sram_pkg::word_idx_w-1:0]  wr_idx,
  output logic [axi_sram_pkg::data_w-1:0]      wr_data,
  output logic [axi_sram_pkg::strb_w-1:0]      wr_strb
);

  import axi_sram_pkg::*;

  localparam int cnt_w = $bits(lat_mask);

  function automatic logic addr_in_range(input logic [addr_w-1:0] a);
    return a[addr_w-1:2] < mem_words;
  endfunction

  logic [cnt_w-1:0] lat_load;

  assign lat_load = lfsr_value[cnt_w-1:0] & lat_mask;

  // ************************************************************
  // Read channel
  // ************************************************************

  logic [addr_w-1:0] rd_addr;
  logic [cnt_w-1:0]  rd_cnt;
  logic              ar_hs;
  logic              rd_fire;
  logic              rd_ok;

  assign ar_hs   = arvalid & arready;
  // Busy while arready is low; hold off until any earlier response is taken
  assign rd_fire = ~arready & (rd_cnt == '0) & ~rvalid;
  assign rd_ok   = addr_in_range(rd_addr);
  assign rd_idx  = rd_addr[word_idx_w+1:2];

  always_ff @(posedge clk) begin
    if (rstn) begin
      arready <= 1'b1;
      rvalid  <= 1'b0;
      rd_cnt  <= '0;
    end else begin
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      if (ar_hs) begin
        arready <= 1'b0;
        rd_cnt  <= lat_load;
      end else if (~arready && rd_cnt != '0) begin
        rd_cnt <= rd_cnt - 1'b1;
      end
      if (rd_fire) begin
        rvalid  <= 1'b1;
        arready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      rd_addr <= araddr;
    end
    if (rd_fire) begin
      rdata <= rd_ok ? rd_data : '0;
      rresp <= rd_ok ? resp_okay : resp_slverr;
    end
  end

  // ************************************************************
  // Write channel
  // ************************************************************

  logic [addr_w-1:0] wr_addr;
  logic [cnt_w-1:0]  wr_cnt;
  logic              aw_hs;
  logic              w_hs;
  logic              wr_start;
  logic              wr_fire;
  logic              wr_ok;

  assign aw_hs = awvalid & awready;
  assign w_hs  = wvalid & wready;

  // Second half of the pair arrives or both arrive together
  assign wr_start = (aw_hs & (~wready | w_hs)) | (w_hs & ~awready);
  assign wr_fire  = ~awready & ~wready & (wr_cnt == '0) & ~bvalid;
  assign wr_ok    = addr_in_range(wr_addr);

  assign wr_en  = wr_fire & wr_ok;
  assign wr_idx = wr_addr[word_idx_w+1:2];

  always_ff @(posedge clk) begin
    if (rstn) begin
      awready <= 1'b1;
      wready  <= 1'b1;
      bvalid  <= 1'b0;
      wr_cnt  <= '0;
    end else begin
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (aw_hs) begin
        awready <= 1'b0;
      end
      if (w_hs) begin
        wready <= 1'b0;
      end
      if (wr_start) begin
        wr_cnt <= lat_load;
      end else if (~awready && ~wready && wr_cnt != '0) begin
        wr_cnt <= wr_cnt - 1'b1;
      end
      if (wr_fire) begin
        bvalid  <= 1'b1;
        awready <= 1'b1;
        wready  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      wr_addr <= awaddr;
    end
    if (w_hs) begin
      wr_data <= wdata;
      wr_strb <= wstrb;
    end
    if (wr_fire) begin
      bresp <= wr_ok ? resp_okay : resp_slverr;
    end
  end

endmodule

`default_nettype wire

// File: src/axi_sram_top.sv
`timescale 1ns/10ps
`default_nettype none

module axi_sram_top (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic [axi_sram_pkg::addr_w-1:0]  araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [axi_sram_pkg::data_w-1:0]  rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  input  logic [axi_sram_pkg::addr_w-1:0]  awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [axi_sram_pkg::data_w-1:0]  wdata,
  input  logic [axi_sram_pkg::strb_w-1:0]  wstrb,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready
);

  import axi_sram_pkg::*;

  logic [7:0]            lfsr_value;
  logic [word_idx_w-1:0] rd_idx;
  logic [data_w-1:0]     rd_data;
  logic                  wr_en;
  logic [word_idx_w-1:0] wr_idx;
  logic [data_w-1:0]     wr_data;
  logic [strb_w-1:0]     wr_strb;

  axi_sram_slave axi_sram_slave_i (
    .clk(clk), .rstn(rstn),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .lfsr_value(lfsr_value),
    .rd_idx(rd_idx), .rd_data(rd_data),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data), .wr_strb(wr_strb)
  );

  lfsr8 lfsr8_i (
    .clk(clk),
    .rstn(rstn),
    .value(lfsr_value)
  );

  sram_array sram_array_i (
    .clk(clk),
    .rd_idx(rd_idx), .rd_data(rd_data),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data), .wr_strb(wr_strb)
  );

endmodule

`default_nettype wire

// File: src/lfsr8.sv
`timescale 1ns/10ps
`default_nettype none

module lfsr8 (
  input  logic       clk,
  input  logic       rstn,
  output logic [7:0] value
);

  import axi_sram_pkg::*;

  logic feedback;

  // Taps 8, 6, 5, 4 give the full 255-state sequence
  assign feedback = value[7] ^ value[5] ^ value[4] ^ value[3];

  always_ff @(posedge clk) begin
    if (rstn) begin
      value <= lfsr_seed;
    end else begin
      value <= {value[6:0], feedback};
    end
  end

endmodule

`default_nettype wire

// File: src/sram_array.sv
`timescale 1ns/10ps
`default_nettype none

module sram_array (
  input  logic                                  clk,
  input  logic [axi_sram_pkg::word_idx_w-1:0]  rd_idx,
  output logic [axi_sram_pkg::data_w-1:0]      rd_data,
  input  logic                                  wr_en,
  input  logic [axi_sram_pkg::word_idx_w-1:0]  wr_idx,
  input  logic [axi_sram_pkg::data_w-1:0]      wr_data,
  input  logic [axi_sram_pkg::strb_w-1:0]      wr_strb
);

  import axi_sram_pkg::*;

  logic [data_w-1:0] mem [mem_words];

  // Start from a known all-zero image
  initial begin
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = '0;
    end
  end

  assign rd_data = mem[rd_idx];

  // Byte lanes written only where the strobe is set
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < strb_w; b++) begin
        if (wr_strb[b]) begin
          mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+tests
src/axi_sram_pkg.sv
src/lfsr8.sv
src/sram_array.sv
src/axi_sram_slave.sv
src/axi_sram_top.sv
tests/tb_axi_sram.sv

// File: tests/axi_lite_tasks.svh
`ifndef AXI_LITE_TASKS_SVH
`define AXI_LITE_TASKS_SVH

// Expected array contents merged per byte lane
logic [data_w-1:0] shadow [mem_words];

function automatic logic in_range(input logic [addr_w-1:0] addr);
  return addr < addr_w'(mem_words * 4);
endfunction

task automatic shadow_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                            input logic [strb_w-1:0] strb);
  for (int b = 0; b < strb_w; b++) begin
    if (strb[b]) begin
      shadow[addr[word_idx_w+1:2]][b*8 +: 8] = data[b*8 +: 8];
    end
  end
endtask

// Order 0 sends AW first, 1 sends W first, 2 sends both together
task automatic write_word(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
                          input logic [strb_w-1:0] strb, input int order);
  int         delay;
  int         timer;
  logic       aw_take;
  logic       w_take;
  logic [1:0] exp_resp;
  delay    = {$random(seed)} % (max_ready_delay + 1);
  exp_resp = in_range(addr) ? resp_okay : resp_slverr;
  awaddr   = addr;
  wdata    = data;
  wstrb    = strb;
  awvalid  = (order != 1);
  wvalid   = (order != 0);
  while (awvalid || wvalid) begin
    aw_take = awvalid && awready;
    w_take  = wvalid && wready;
    @(posedge clk);
    #1;
    if (aw_take) begin
      awvalid = 1'b0;
      wvalid  = wvalid || (order == 0);
    end
    if (w_take) begin
      wvalid  = 1'b0;
      awvalid = awvalid || (order == 1);
    end
  end
  // Response held off by a random bready delay
  timer = 0;
  while (!bready) begin
    @(posedge clk);
    #1;
    if (bvalid && timer >= delay) begin
      bready = 1'b1;
    end else if (bvalid) begin
      timer++;
    end
  end
  assert (bresp == exp_resp) else begin
    errors++;
    $display("ERR %0t: write 0x%08h bresp %0d, expected %0d", $time, addr, bresp, exp_resp);
  end
  if (exp_resp == resp_okay) begin
    shadow_write(addr, data, strb);
  end
  @(posedge clk);
  #1;
  bready = 1'b0;
endtask

task automatic read_word(input logic [addr_w-1:0] addr);
  int                delay;
  int                timer;
  logic              ar_take;
  logic [data_w-1:0] exp_data;
  logic [1:0]        exp_resp;
  delay    = {$random(seed)} % (max_ready_delay + 1);
  exp_resp = in_range(addr) ? resp_okay : resp_slverr;
  exp_data = in_range(addr) ? shadow[addr[word_idx_w+1:2]] : '0;
  araddr   = addr;
  arvalid  = 1'b1;
  while (arvalid) begin
    ar_take = arready;
    @(posedge clk);
    #1;
    if (ar_take) begin
      arvalid = 1'b0;
    end
  end
  timer = 0;
  while (!rready) begin
    @(posedge clk);
    #1;
    if (rvalid && timer >= delay) begin
      rready = 1'b1;
    end else if (rvalid) begin
      timer++;
    end
  end
  assert (rdata == exp_data && rresp == exp_resp) else begin
    errors++;
    $display("ERR %0t: read 0x%08h got 0x%08h/%0d, expected 0x%08h/%0d", $time, addr,
             rdata, rresp, exp_data, exp_resp);
  end
  @(posedge clk);
  #1;
  rready = 1'b0;
endtask

`endif

// File: tests/tb_axi_sram.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_sram;

  import axi_sram_pkg::*;

  localparam int max_ready_delay = 6;
  localparam int max_lat         = int'(lat_mask) + 1;
  localparam int n_trans         = 42;
  localparam int timeout_cycles  = n_trans * (max_lat + max_ready_delay + 4) + 20;

  logic              clk;
  logic              rstn;
  logic [addr_w-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [data_w-1:0] rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;
  logic [addr_w-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [data_w-1:0] wdata;
  logic [strb_w-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;

  int seed;
  int errors = 0;
  int ar_acc = 0;
  int wr_acc = 0;
  int rd_age;
  int wr_age;
  logic aw_got;
  logic w_got;
  logic aw_hs;
  logic w_hs;

  `include "axi_lite_tasks.svh"

  axi_sram_top axi_sram_top_i (
    .clk(clk), .rstn(rstn),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("Timeout after %0d cycles, a handshake never completed", timeout_cycles);
    $display("tests failed");
    $finish;
  end

  // ************************************************************
  // Request age and response tracking
  // ************************************************************

  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;

  always @(posedge clk) begin
    if (rstn) begin
      rd_age <= 0;
      wr_age <= 0;
      aw_got <= 1'b0;
      w_got  <= 1'b0;
    end else begin
      if (rd_age != 0) begin
        rd_age <= rvalid ? 0 : rd_age + 1;
      end
      if (arvalid && arready) begin
        rd_age <= 1;
        ar_acc <= ar_acc + 1;
      end
      if (wr_age != 0) begin
        wr_age <= bvalid ? 0 : wr_age + 1;
      end
      // Write request complete once both halves are in
      if ((aw_hs || w_hs) && (aw_hs || aw_got) && (w_hs || w_got)) begin
        wr_age <= 1;
        wr_acc <= wr_acc + 1;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end else begin
        aw_got <= aw_got || aw_hs;
        w_got  <= w_got || w_hs;
      end
    end
  end

  // ************************************************************
  // Protocol assertions
  // ************************************************************

  assert property (@(posedge clk) $fell(rstn) |-> arready && awready && wready && !rvalid
                   && !bvalid)
    else begin
      errors++;
      $display("ERR %0t: ready/valid levels wrong after reset", $time);
    end

  assert property (@(posedge clk) disable iff (rstn)
                   rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      errors++;
      $display("ERR %0t: read response changed under back-pressure", $time);
    end

  assert property (@(posedge clk) disable iff (rstn)
                   bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      errors++;
      $display("ERR %0t: write response changed under back-pressure", $time);
    end

  assert property (@(posedge clk) disable iff (rstn)
                   (rd_age != 0 && !rvalid) |-> rd_age <= max_lat)
    else begin
      errors++;
      $display("ERR %0t: read response later than %0d cycles", $time, max_lat);
    end

  assert property (@(posedge clk) disable iff (rstn)
                   (wr_age != 0 && !bvalid) |-> wr_age <= max_lat)
    else begin
      errors++;
      $display("ERR %0t: write response later than %0d cycles", $time, max_lat);
    end

  assert property (@(posedge clk) disable iff (rstn) $rose(rvalid) |-> rd_age != 0)
    else begin
      errors++;
      $display("ERR %0t: read response without an accepted request", $time);
    end

  assert property (@(posedge clk) disable iff (rstn) $rose(bvalid) |-> wr_age != 0)
    else begin
      errors++;
      $display("ERR %0t: write response without an accepted request", $time);
    end

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin
    logic [addr_w-1:0] addr;
    logic [addr_w-1:0] oor;
    logic [strb_w-1:0] strb;
    seed    = 32'h312f;
    rstn    = 1'b1;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    foreach (shadow[i]) begin
      shadow[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b0;
    @(posedge clk);
    #1;

    // Full-strobe writes through all AW/W orderings
    for (int i = 0; i < 12; i++) begin
      addr = ({$random(seed)} % mem_words) * 4;
      write_word(addr, $random(seed), '1, i % 3);
      read_word(addr);
    end

    // Byte lanes merge
    for (int k = 0; k < 2; k++) begin
      addr = ({$random(seed)} % mem_words) * 4;
      for (int j = 0; j < 4; j++) begin
        strb = $random(seed);
        write_word(addr, $random(seed), strb, j % 3);
      end
      read_word(addr);
    end

    // Out-of-range accesses leave the aliased word untouched
    for (int k = 0; k < 2; k++) begin
      addr = ({$random(seed)} % mem_words) * 4;
      write_word(addr, $random(seed), '1, 2);
      oor = (k == 0) ? addr + mem_words * 4 : addr | 32'hf000_0000;
      write_word(oor, $random(seed), '1, k);
      read_word(oor);
      read_word(addr);
    end

    repeat (2) @(posedge clk);
    $display("Errors: %0d, reads: %0d, writes: %0d", errors, ar_acc, wr_acc);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
